// ==== rv_core_pkg.sv ====
/* RV32I core package
   Word and register types, opcode, ALU and forwarding codes */
package rv_core_pkg;

    // ==============================
    // Basic types
    // ==============================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    // ALU operation selectors
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;

    // Operand source in EX
    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    // ==============================
    // Opcodes of the supported subset
    // ==============================
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;

    // ADDI x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== rv_pipe_if.sv ====
/* Pipeline stage-boundary bundles, ID/EX and EX/MEM */
interface id_ex_if import rv_core_pkg::*; ();
    // Payload
    word_t      pc;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    alu_op_t    alu_op;
    logic [2:0] funct3;
    // Control bits, cleared for a bubble
    logic       use_imm;
    logic       zero_a;
    logic       regwrite;
    logic       memread;
    logic       memwrite;
    logic       branch;
    logic       jump;

    modport decode (
        output pc, rs1_val, rs2_val, imm, rs1, rs2, rd, alu_op, funct3,
        output use_imm, zero_a, regwrite, memread, memwrite, branch, jump
    );
    modport execute (
        input pc, rs1_val, rs2_val, imm, rs1, rs2, rd, alu_op, funct3,
        input use_imm, zero_a, regwrite, memread, memwrite, branch, jump
    );
endinterface

interface ex_mem_if import rv_core_pkg::*; ();
    word_t    alu_result;
    word_t    store_data;
    word_t    link_pc;
    reg_idx_t rd;
    logic     regwrite;
    logic     memread;
    logic     memwrite;
    logic     jump;

    modport execute (
        output alu_result, store_data, link_pc, rd,
        output regwrite, memread, memwrite, jump
    );
    // Store side is taken straight off the bundle by the top level
    modport mem_wb (
        input alu_result, link_pc, rd, regwrite, memread, jump
    );
endinterface

// ==== rv_fetch.sv ====
/* Fetch stage
   Program counter with stall and redirect, plus the IF/ID register */
module rv_fetch import rv_core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t imem_addr,
    input  word_t imem_rdata,
    output word_t instr,
    output word_t instr_pc
);

    word_t pc;

    assign imem_addr = pc;

    // Redirect takes priority over a load-use hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= RESET_PC;
            instr    <= NOP_INSTR;
            instr_pc <= RESET_PC;
        end else if (redirect) begin
            pc    <= redirect_pc;
            // Squash the wrong-path fetch
            instr <= NOP_INSTR;
        end else if (!stall) begin
            pc       <= pc + 32'd4;
            instr    <= imem_rdata;
            instr_pc <= pc;
        end
    end

endmodule

// ==== rv_regfile.sv ====
/* Integer register file, 32 x 32, x0 tied to zero, write-first reads */
module rv_regfile import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_val,
    output word_t    rs2_val,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data
);

    word_t regs [32];
    logic  wr_active;

    // Writes to x0 are dropped
    assign wr_active = wb_en && (wb_rd != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_active) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Bypass covers a producer three slots ahead
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wr_active && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wr_active && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

// ==== rv_decode.sv ====
/* Decode stage
   Control and immediate generation, load-use detection, ID/EX register */
module rv_decode import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    instr,
    input  word_t    instr_pc,
    input  logic     redirect,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output logic     stall,
    id_ex_if.decode  id_ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
    alu_op_t    arith_op;
    logic       arith_ok;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       zero_a;
    logic       regwrite;
    logic       memread;
    logic       memwrite;
    logic       branch;
    logic       jump;
    logic       bubble;

    // ==============================
    // Field split
    // ==============================
    assign opcode    = instr[6:0];
    assign rd        = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign funct7_b5 = instr[30];

    rv_regfile i_rv_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    // Arithmetic funct3 shared by R and I forms
    always_comb begin
        arith_ok = 1'b1;
        case (funct3)
            3'b000:  arith_op = (opcode == OP_R && funct7_b5) ? ALU_SUB : ALU_ADD;
            3'b010:  arith_op = ALU_SLT;
            3'b100:  arith_op = ALU_XOR;
            3'b110:  arith_op = ALU_OR;
            3'b111:  arith_op = ALU_AND;
            default: begin
                // Shifts and SLTU are not supported
                arith_op = ALU_ADD;
                arith_ok = 1'b0;
            end
        endcase
    end

    // ==============================
    // Control and immediate
    // ==============================
    always_comb begin
        alu_op   = ALU_ADD;
        imm      = '0;
        use_imm  = 1'b0;
        zero_a   = 1'b0;
        regwrite = 1'b0;
        memread  = 1'b0;
        memwrite = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        case (opcode)
            OP_R: begin
                alu_op   = arith_op;
                regwrite = arith_ok;
            end
            OP_I: begin
                alu_op   = arith_op;
                imm      = {{20{instr[31]}}, instr[31:20]};
                use_imm  = 1'b1;
                regwrite = arith_ok;
            end
            OP_LUI: begin
                // Zero plus upper immediate
                imm      = {instr[31:12], 12'b0};
                use_imm  = 1'b1;
                zero_a   = 1'b1;
                regwrite = 1'b1;
            end
            OP_LOAD: begin
                imm      = {{20{instr[31]}}, instr[31:20]};
                use_imm  = 1'b1;
                memread  = (funct3 == 3'b010);
                regwrite = (funct3 == 3'b010);
            end
            OP_STORE: begin
                imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm  = 1'b1;
                memwrite = (funct3 == 3'b010);
            end
            OP_BRANCH: begin
                imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
                branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE) || (funct3 == F3_BLT);
            end
            OP_JAL: begin
                imm      = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
                jump     = 1'b1;
                regwrite = 1'b1;
            end
            // Anything else stays a bubble
            default: ;
        endcase
    end

    // Load in EX feeding this instruction, hold for one slot
    assign stall = id_ex.memread && (id_ex.rd != '0) &&
                   ((id_ex.rd == rs1) || (id_ex.rd == rs2));

    assign bubble = redirect || stall;

    // ==============================
    // ID/EX register
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex.use_imm  <= 1'b0;
            id_ex.zero_a   <= 1'b0;
            id_ex.regwrite <= 1'b0;
            id_ex.memread  <= 1'b0;
            id_ex.memwrite <= 1'b0;
            id_ex.branch   <= 1'b0;
            id_ex.jump     <= 1'b0;
        end else begin
            id_ex.use_imm  <= use_imm && !bubble;
            id_ex.zero_a   <= zero_a && !bubble;
            id_ex.regwrite <= regwrite && !bubble;
            id_ex.memread  <= memread && !bubble;
            id_ex.memwrite <= memwrite && !bubble;
            id_ex.branch   <= branch && !bubble;
            id_ex.jump     <= jump && !bubble;
        end
    end

    // Payload follows every cycle
    always_ff @(posedge clk) begin
        id_ex.pc      <= instr_pc;
        id_ex.rs1_val <= rs1_val;
        id_ex.rs2_val <= rs2_val;
        id_ex.imm     <= imm;
        id_ex.rs1     <= rs1;
        id_ex.rs2     <= rs2;
        id_ex.rd      <= rd;
        id_ex.alu_op  <= alu_op;
        id_ex.funct3  <= funct3;
    end

endmodule

// ==== rv_execute.sv ====
/* Execute stage
   Operand forwarding, ALU, branch resolution and the EX/MEM register */
module rv_execute import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    id_ex_if.execute  id_ex,
    ex_mem_if.execute ex_mem,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output logic     redirect,
    output word_t    redirect_pc
);

    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    word_t    mem_val;
    word_t    rs1_fwd;
    word_t    rs2_fwd;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_res;
    logic     rs_eq;
    logic     rs_lt;
    logic     taken;

    // Youngest producer wins, x0 never forwards
    function automatic fwd_sel_t fwd_pick(reg_idx_t rs);
        fwd_sel_t sel;
        sel = FWD_REG;
        if (ex_mem.regwrite && ex_mem.rd != '0 && ex_mem.rd == rs) begin
            sel = FWD_MEM;
        end else if (wb_en && wb_rd != '0 && wb_rd == rs) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    // ==============================
    // Forwarding
    // ==============================
    assign fwd_a = fwd_pick(id_ex.rs1);
    assign fwd_b = fwd_pick(id_ex.rs2);

    // JAL in MEM hands over its link address
    assign mem_val = ex_mem.jump ? ex_mem.link_pc : ex_mem.alu_result;

    always_comb begin
        case (fwd_a)
            FWD_MEM: rs1_fwd = mem_val;
            FWD_WB:  rs1_fwd = wb_data;
            default: rs1_fwd = id_ex.rs1_val;
        endcase
        case (fwd_b)
            FWD_MEM: rs2_fwd = mem_val;
            FWD_WB:  rs2_fwd = wb_data;
            default: rs2_fwd = id_ex.rs2_val;
        endcase
    end

    // LUI adds to zero
    assign op_a = id_ex.zero_a ? '0 : rs1_fwd;
    assign op_b = id_ex.use_imm ? id_ex.imm : rs2_fwd;

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    // Branch compare on forwarded registers
    assign rs_eq = (rs1_fwd == rs2_fwd);
    assign rs_lt = $signed(rs1_fwd) < $signed(rs2_fwd);

    always_comb begin
        case (id_ex.funct3)
            F3_BEQ:  taken = rs_eq;
            F3_BNE:  taken = !rs_eq;
            F3_BLT:  taken = rs_lt;
            default: taken = 1'b0;
        endcase
    end

    // Flushes IF/ID and the next ID/EX load
    assign redirect    = (id_ex.branch && taken) || id_ex.jump;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    // ==============================
    // EX/MEM register
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem.regwrite <= 1'b0;
            ex_mem.memread  <= 1'b0;
            ex_mem.memwrite <= 1'b0;
            ex_mem.jump     <= 1'b0;
        end else begin
            ex_mem.regwrite <= id_ex.regwrite;
            ex_mem.memread  <= id_ex.memread;
            ex_mem.memwrite <= id_ex.memwrite;
            ex_mem.jump     <= id_ex.jump;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.alu_result <= alu_res;
        ex_mem.store_data <= rs2_fwd;
        ex_mem.link_pc    <= id_ex.pc + 32'd4;
        ex_mem.rd         <= id_ex.rd;
    end

endmodule

// ==== rv_mem_wb.sv ====
/* Memory-to-writeback register and writeback source select */
module rv_mem_wb import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    ex_mem_if.mem_wb ex_mem,
    input  word_t    dmem_rdata,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    logic  wb_load;
    logic  wb_jump;
    word_t wb_alu;
    word_t wb_mem;
    word_t wb_link;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en   <= 1'b0;
            wb_load <= 1'b0;
            wb_jump <= 1'b0;
        end else begin
            wb_en   <= ex_mem.regwrite;
            wb_load <= ex_mem.memread;
            wb_jump <= ex_mem.jump;
        end
    end

    // Load data answers in the MEM cycle
    always_ff @(posedge clk) begin
        wb_rd   <= ex_mem.rd;
        wb_alu  <= ex_mem.alu_result;
        wb_mem  <= dmem_rdata;
        wb_link <= ex_mem.link_pc;
    end

    // Link, then load data, then ALU
    assign wb_data = wb_jump ? wb_link : (wb_load ? wb_mem : wb_alu);

endmodule

// ==== rv_core.sv ====
/* RV32I five-stage pipeline top
   Connects the stages to the instruction and data memory ports */
module rv_core import rv_core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst,
    output word_t imem_addr,
    input  word_t imem_rdata,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_valid,
    output logic  dmem_we,
    input  word_t dmem_rdata
);

    word_t    instr;
    word_t    instr_pc;
    logic     stall;
    logic     redirect;
    word_t    redirect_pc;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) i_rv_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

    rv_decode i_rv_decode (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .instr_pc (instr_pc),
        .redirect (redirect),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .stall    (stall),
        .id_ex    (id_ex.decode)
    );

    rv_execute i_rv_execute (
        .clk         (clk),
        .rst         (rst),
        .id_ex       (id_ex.execute),
        .ex_mem      (ex_mem.execute),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    rv_mem_wb i_rv_mem_wb (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem.mem_wb),
        .dmem_rdata (dmem_rdata),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    // Data port driven straight from the MEM stage
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_valid = ex_mem.memread || ex_mem.memwrite;
    assign dmem_we    = ex_mem.memwrite;

endmodule

// ==== rv_core_properties.sv ====
/* Port rules of the pipeline top, bound into rv_core */
module rv_core_properties import rv_core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input logic  clk,
    input logic  rst,
    input word_t imem_addr,
    input logic  dmem_valid,
    input logic  dmem_we
);

    timeunit 1ns;
    timeprecision 100ps;

    // A store is always a valid access
    a_we_needs_valid : assert property (@(posedge clk) disable iff (rst)
        dmem_we |-> dmem_valid)
        else $error("dmem_we high without dmem_valid");

    // Data port quiet in reset
    a_quiet_in_reset : assert property (@(posedge clk) rst |-> !dmem_valid)
        else $error("dmem_valid high during reset");

    a_pc_aligned : assert property (@(posedge clk) disable iff (rst)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned");

    // First fetch after release
    a_reset_pc : assert property (@(posedge clk) $fell(rst) |-> imem_addr == RESET_PC)
        else $error("imem_addr not at reset PC after reset");

endmodule

bind rv_core rv_core_properties #(
    .RESET_PC (RESET_PC)
) i_rv_core_properties (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .dmem_valid (dmem_valid),
    .dmem_we    (dmem_we)
);

// ==== tb_rv_core.sv ====
/* Testbench for the RV32I pipeline
   Memory models, program table and in-order store checking */
module tb_rv_core import rv_core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN     = 54;
    localparam int QUIET_CYCLES = 10;
    // Generous bound on pipeline fill, stalls and redirects
    localparam int CYCLE_LIMIT  = 4 * PROG_LEN + 40;

    logic  clk = 1'b0;
    logic  rst;
    word_t imem_addr;
    word_t imem_rdata = '0;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_valid;
    logic  dmem_we;
    word_t dmem_rdata = '0;

    word_t imem [PROG_LEN];
    word_t dmem [16];
    word_t data_init [16];
    word_t exp_addr [$];
    word_t exp_data [$];

    // ==============================
    // Program, one instruction per row
    // ==============================
    localparam word_t PROG [PROG_LEN] = '{
        32'h03C02283, 32'h00728313, 32'h00602023,  // lw x5,60(x0); addi x6,x5,7; sw x6,0
        32'h123280B7, 32'hFFD00113, 32'h05A00193,  // lui x1 (rs1 field x5); addi x2; addi x3
        32'h00F1F213, 32'h1001E393, 32'hFFF1C413,  // andi x4; ori x7; xori x8
        32'h00012493, 32'h00218533, 32'h402185B3,  // slti x9; add x10; sub x11
        32'h00317633, 32'h0030E6B3, 32'h0020C733,  // and x12; or x13; xor x14
        32'h003127B3,                              // slt x15,x2,x3
        32'h00102223, 32'h00202423, 32'h00302623,  // sw x1,4; sw x2,8; sw x3,12
        32'h00402823, 32'h00702A23, 32'h00802C23,  // sw x4,16; sw x7,20; sw x8,24
        32'h00902E23, 32'h02A02023, 32'h02B02223,  // sw x9,28; sw x10,32; sw x11,36
        32'h02C02423, 32'h02D02623, 32'h02E02823,  // sw x12,40; sw x13,44; sw x14,48
        32'h02F02A23,                              // sw x15,52
        32'h06400813, 32'h00180893, 32'h00280913,  // addi x16,x0,100; x17; x18
        32'h00380993,                              // addi x19,x16,3
        32'h01102223, 32'h01202423, 32'h01302623,  // sw x17,4; sw x18,8; sw x19,12
        32'h00500013, 32'h00002823,                // addi x0,x0,5; sw x0,16
        32'h00318663, 32'h00102E23, 32'h00102E23,  // beq x3,x3,+12; two skipped stores
        32'h00219663, 32'h00102E23, 32'h00102E23,  // bne x3,x2,+12; skipped
        32'h00314663, 32'h00102E23, 32'h00102E23,  // blt x2,x3,+12; skipped
        32'h00218463, 32'h00302A23,                // beq x3,x2,+8 not taken; sw x3,20
        32'h00C00A6F, 32'h00102E23, 32'h00102E23,  // jal x20,+12 at 0xc4; skipped
        32'h01402C23, 32'h0000006F                 // sw x20,24; jal x0,0
    };

    rv_core #(
        .RESET_PC (32'h0)
    ) i_rv_core (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_valid (dmem_valid),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #4 clk = ~clk;

    // Galois LFSR, one step per output bit
    function automatic word_t lfsr_step(word_t s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Expected store, optionally plus seeded data word k
    task automatic add_row(word_t addr, word_t value, bit plus_word, logic [3:0] k);
        exp_addr.push_back(addr);
        exp_data.push_back(plus_word ? value + data_init[k] : value);
    endtask

    // ==============================
    // Memory models
    // ==============================
    always @(negedge clk) begin
        if ((imem_addr >> 2) < word_t'(PROG_LEN)) begin
            imem_rdata <= imem[imem_addr[7:2]];
        end else begin
            imem_rdata <= NOP_INSTR;
        end
        // Read data only for an active access
        dmem_rdata <= dmem_valid ? dmem[dmem_addr[5:2]] : '0;
    end

    // Reloaded from the seed words while in reset
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                dmem[i] = data_init[i];
            end
        end else if (dmem_valid && dmem_we) begin
            dmem[dmem_addr[5:2]] = dmem_wdata;
        end
    end

    // ==============================
    // Stimulus and store checking
    // ==============================
    initial begin
        word_t lfsr;
        int    row;
        int    cycles;
        int    quiet;
        bit    done;

        rst = 1'b1;
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = PROG[i];
        end
        lfsr = 32'd21;
        for (int w = 0; w < 16; w++) begin
            for (int b = 0; b < 32; b++) begin
                data_init[w][b] = lfsr[0];
                lfsr = lfsr_step(lfsr);
            end
        end

        // Load-use result, then ALU results in store order
        add_row(32'd0, 32'd7, 1'b1, 4'd15);
        add_row(32'd4, 32'h1232_8000, 1'b0, 4'd0);
        add_row(32'd8, 32'hFFFF_FFFD, 1'b0, 4'd0);
        add_row(32'd12, 32'h0000_005A, 1'b0, 4'd0);
        add_row(32'd16, 32'h0000_000A, 1'b0, 4'd0);
        add_row(32'd20, 32'h0000_015A, 1'b0, 4'd0);
        add_row(32'd24, 32'hFFFF_FFA5, 1'b0, 4'd0);
        add_row(32'd28, 32'd1, 1'b0, 4'd0);
        add_row(32'd32, 32'h0000_0057, 1'b0, 4'd0);
        add_row(32'd36, 32'h0000_005D, 1'b0, 4'd0);
        add_row(32'd40, 32'h0000_0058, 1'b0, 4'd0);
        add_row(32'd44, 32'h1232_805A, 1'b0, 4'd0);
        add_row(32'd48, 32'hEDCD_7FFD, 1'b0, 4'd0);
        add_row(32'd52, 32'd1, 1'b0, 4'd0);
        // Forwarding at distance 1, 2 and 3
        add_row(32'd4, 32'd101, 1'b0, 4'd0);
        add_row(32'd8, 32'd102, 1'b0, 4'd0);
        add_row(32'd12, 32'd103, 1'b0, 4'd0);
        // x0 stays zero
        add_row(32'd16, 32'd0, 1'b0, 4'd0);
        // Fall-through store, then link of the jal at 0xc4
        add_row(32'd20, 32'h0000_005A, 1'b0, 4'd0);
        add_row(32'd24, 32'h0000_00C8, 1'b0, 4'd0);

        repeat (10) @(negedge clk);
        rst = 1'b0;

        row    = 0;
        cycles = 0;
        quiet  = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (dmem_valid && dmem_we) begin
                if (row >= exp_addr.size()) begin
                    $display("Store to address %h after all expected stores had arrived",
                             dmem_addr);
                    stop_on_failure();
                end
                check_value("dmem_addr", exp_addr[row], dmem_addr);
                check_value("dmem_wdata", exp_data[row], dmem_wdata);
                row++;
                quiet = 0;
            end else if (row == exp_addr.size()) begin
                quiet++;
            end
            if (quiet >= QUIET_CYCLES) begin
                done = 1'b1;
            end else if (cycles >= CYCLE_LIMIT) begin
                $display("Timeout after %0d cycles, only %0d of %0d stores arrived",
                         cycles, row, exp_addr.size());
                done = 1'b1;
            end
        end

        if (row == exp_addr.size() && quiet >= QUIET_CYCLES) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

// ==== list.f ====
rv_core_pkg.sv
rv_pipe_if.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_mem_wb.sv
rv_core.sv
rv_core_properties.sv
tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the RV32I pipeline testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_rv_core -f list.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
